// File: filelist.f
source/uart_pkg.sv
source/baud_timer.sv
source/credit_fifo.sv
source/uart_tx_ctrl.sv
source/uart_rx_ctrl.sv
source/uart_top.sv
tests/tb_uart_top.sv

// File: Bender.yml
package:
  name: uart_subsystem

sources:
  - files:
      - source/uart_pkg.sv
      - source/baud_timer.sv
      - source/credit_fifo.sv
      - source/uart_tx_ctrl.sv
      - source/uart_rx_ctrl.sv
      - source/uart_top.sv
  - target: test
    files:
      - tests/tb_uart_top.sv

// File: tests/tb_uart_top.sv
// directed testbench for the uart subsystem
// loopback serial line, host credit model, receive monitor and five tests

`timescale 1ns/1ps

module tb_uart_top import uart_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 30 * 10 * CLKS_PER_BIT + 500;
    localparam int BP_FRAMES      = RX_HOST_CREDITS + FIFO_DEPTH + 1;  // last one overruns

    logic        sys_clk;
    logic        sys_rst;
    logic        tx_valid;
    logic [7:0]  tx_data;
    logic        tx_credit;
    logic        txd;
    logic        tx_busy;
    logic        rxd;
    logic        rx_valid;
    logic [7:0]  rx_data;
    logic        rx_frame_err;
    logic        rx_credit;
    logic        rx_overrun;

    logic        line_own;        // rxd driven by hand, not looped back
    logic        hold_rx_credit;
    int          host_credits;    // tx credits the host holds
    int          credits_seen;
    int          overruns;
    int          pending_rx_credit;
    int          cycles;
    logic [31:0] lcg_state;
    logic [8:0]  rx_got[$];       // {frame_err, data} per rx_valid

    uart_top i_uart_top (
        .sys_clk      (sys_clk),
        .sys_rst      (sys_rst),
        .tx_valid     (tx_valid),
        .tx_data      (tx_data),
        .tx_credit    (tx_credit),
        .txd          (txd),
        .tx_busy      (tx_busy),
        .rxd          (rxd),
        .rx_valid     (rx_valid),
        .rx_data      (rx_data),
        .rx_frame_err (rx_frame_err),
        .rx_credit    (rx_credit),
        .rx_overrun   (rx_overrun)
    );

    always #20 sys_clk = ~sys_clk;

    // txd looped back onto rxd unless a test owns the line
    always @(posedge sys_clk) begin
        #2;
        if (!line_own)
            rxd = txd;
    end

    // host hands back one rx credit per frame taken
    always @(posedge sys_clk) begin
        #2;
        if (!hold_rx_credit && pending_rx_credit > 0) begin
            rx_credit = 1'b1;
            pending_rx_credit--;
        end else begin
            rx_credit = 1'b0;
        end
    end

    always @(negedge sys_clk) begin
        if (sys_rst) begin
            if (rx_valid) begin
                rx_got.push_back({rx_frame_err, rx_data});
                pending_rx_credit++;
            end
            if (tx_credit) begin
                credits_seen++;
                host_credits++;
            end
            if (rx_overrun)
                overruns++;
        end
    end

    always @(posedge sys_clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $fatal(1, "run stopped on timeout");
        end
    end

    function automatic logic [7:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Some tests failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    // leaves the caller 2 ns after a rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge sys_clk);
        #2;
    endtask

    task automatic send_byte(input logic [7:0] b);
        while (host_credits == 0)
            wait_cycles(1);
        tx_valid = 1'b1;
        tx_data  = b;
        host_credits--;
        wait_cycles(1);
        tx_valid = 1'b0;
    endtask

    task automatic drive_serial_frame(input logic [7:0] b, input logic stop_bit);
        line_own = 1'b1;
        rxd      = 1'b0;
        wait_cycles(CLKS_PER_BIT);
        for (int i = 0; i < DATA_BITS; i++) begin
            rxd = b[i];
            wait_cycles(CLKS_PER_BIT);
        end
        rxd = stop_bit;
        wait_cycles(CLKS_PER_BIT);
        rxd = 1'b1;
        wait_cycles(2 * CLKS_PER_BIT);  // idle gap
    endtask

    task automatic wait_rx(input int n);
        while (rx_got.size() < n)
            wait_cycles(1);
    endtask

    task automatic wait_idle();
        while (tx_busy)
            wait_cycles(1);
        wait_cycles(2 * CLKS_PER_BIT);
    endtask

    task automatic check_frame(input logic [7:0] data, input logic err);
        logic [8:0] f;
        f = rx_got.pop_front();
        check_eq("rx_data", f[7:0], data);
        check_eq("rx_frame_err", f[8], err);
    endtask

    task automatic test_reset_state();
        check_eq("txd", txd, 1);
        check_eq("tx_credit", tx_credit, 0);
        check_eq("rx_valid", rx_valid, 0);
        check_eq("rx_overrun", rx_overrun, 0);
        check_eq("tx_busy", tx_busy, 0);
    endtask

    task automatic test_single_frame();
        logic [7:0] b;
        int         credits_before;
        b = next_random();
        credits_before = credits_seen;
        send_byte(b);
        while (txd !== 1'b0)
            wait_cycles(1);
        wait_cycles(HALF_BIT);  // centre of start bit
        check_eq("txd start bit", txd, 0);
        for (int i = 0; i < DATA_BITS; i++) begin
            wait_cycles(CLKS_PER_BIT);
            check_eq("txd data bit", txd, b[i]);
        end
        wait_cycles(CLKS_PER_BIT);
        check_eq("txd stop bit", txd, 1);
        wait_rx(1);
        check_frame(b, 1'b0);
        wait_idle();
        check_eq("tx_credit pulses", credits_seen - credits_before, 1);
    endtask

    task automatic test_tx_credits();
        logic [7:0] sent[FIFO_DEPTH];
        int         credits_before;
        credits_before = credits_seen;
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            sent[i] = next_random();
            send_byte(sent[i]);  // back to back on initial credits
        end
        wait_rx(FIFO_DEPTH);
        for (int i = 0; i < FIFO_DEPTH; i++)
            check_frame(sent[i], 1'b0);
        wait_idle();
        check_eq("tx_credit pulses", credits_seen - credits_before, FIFO_DEPTH);
    endtask

    task automatic test_rx_backpressure();
        logic [7:0] sent[BP_FRAMES];
        int         overruns_before;
        overruns_before = overruns;
        hold_rx_credit  = 1'b1;
        for (int i = 0; i < BP_FRAMES; i++) begin
            sent[i] = next_random();
            send_byte(sent[i]);
        end
        while (overruns == overruns_before)
            wait_cycles(1);
        wait_idle();
        check_eq("rx_valid count without credit", rx_got.size(), RX_HOST_CREDITS);
        check_eq("rx_overrun pulses", overruns - overruns_before, 1);
        for (int i = 0; i < RX_HOST_CREDITS; i++)
            check_frame(sent[i], 1'b0);
        hold_rx_credit = 1'b0;
        wait_rx(FIFO_DEPTH);
        wait_cycles(4 * CLKS_PER_BIT);  // dropped frame must not show up
        check_eq("rx_valid count after credit", rx_got.size(), FIFO_DEPTH);
        for (int i = 0; i < FIFO_DEPTH; i++)
            check_frame(sent[RX_HOST_CREDITS + i], 1'b0);
    endtask

    task automatic test_framing_error();
        logic [7:0] bad;
        logic [7:0] good;
        bad  = next_random();
        good = next_random();
        drive_serial_frame(bad, 1'b0);
        drive_serial_frame(good, 1'b1);
        line_own = 1'b0;
        wait_rx(2);
        check_frame(bad, 1'b1);
        check_frame(good, 1'b0);
    endtask

    initial begin
        sys_clk           = 1'b0;
        sys_rst           = 1'b0;
        tx_valid          = 1'b0;
        tx_data           = 8'h00;
        rxd               = 1'b1;
        rx_credit         = 1'b0;
        line_own          = 1'b0;
        hold_rx_credit    = 1'b0;
        host_credits      = FIFO_DEPTH;
        credits_seen      = 0;
        overruns          = 0;
        pending_rx_credit = 0;
        cycles            = 0;
        lcg_state         = 32'd92;
        repeat (10) @(posedge sys_clk);
        #2;
        sys_rst = 1'b1;
        wait_cycles(2);

        test_reset_state();
        test_single_frame();
        test_tx_credits();
        test_rx_backpressure();
        test_framing_error();

        $display("All tests passed");
        $finish;
    end

endmodule

// File: source/uart_top.sv
// uart subsystem top
// tx buffer, tx FSM and timer; rx FSM, timer and rx buffer

`timescale 1ns/1ps

module uart_top import uart_pkg::*; (
    input  logic       sys_clk,
    input  logic       sys_rst,
    input  logic       tx_valid,
    input  logic [7:0] tx_data,
    output logic       tx_credit,
    output logic       txd,
    output logic       tx_busy,
    input  logic       rxd,
    output logic       rx_valid,
    output logic [7:0] rx_data,
    output logic       rx_frame_err,
    input  logic       rx_credit,
    output logic       rx_overrun
);

    logic       tx_byte_valid;
    logic [7:0] tx_byte_data;
    logic       tx_byte_credit;
    logic       tx_run;
    logic       tx_tick;

    logic       rx_run;
    logic       rx_half;
    logic       rx_tick;
    logic       rx_push;
    rx_frame_t  rx_push_frame;
    logic       rx_push_credit;
    rx_frame_t  rx_frame;

    assign rx_data      = rx_frame.data;
    assign rx_frame_err = rx_frame.frame_err;

    credit_fifo #(
        .payload_t    (logic [7:0]),
        .INIT_CREDITS (1)  // one frame in the shifter
    ) i_tx_fifo (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .in_valid   (tx_valid),
        .in_data    (tx_data),
        .in_credit  (tx_credit),
        .out_valid  (tx_byte_valid),
        .out_data   (tx_byte_data),
        .out_credit (tx_byte_credit)
    );

    baud_timer i_tx_timer (
        .sys_clk (sys_clk),
        .sys_rst (sys_rst),
        .run     (tx_run),
        .half    (1'b0),
        .tick    (tx_tick)
    );

    uart_tx_ctrl i_uart_tx_ctrl (
        .sys_clk     (sys_clk),
        .sys_rst     (sys_rst),
        .byte_valid  (tx_byte_valid),
        .byte_data   (tx_byte_data),
        .byte_credit (tx_byte_credit),
        .run         (tx_run),
        .tick        (tx_tick),
        .txd         (txd),
        .tx_busy     (tx_busy)
    );

    baud_timer i_rx_timer (
        .sys_clk (sys_clk),
        .sys_rst (sys_rst),
        .run     (rx_run),
        .half    (rx_half),
        .tick    (rx_tick)
    );

    uart_rx_ctrl i_uart_rx_ctrl (
        .sys_clk      (sys_clk),
        .sys_rst      (sys_rst),
        .rxd          (rxd),
        .run          (rx_run),
        .half         (rx_half),
        .tick         (rx_tick),
        .frame_valid  (rx_push),
        .frame_data   (rx_push_frame),
        .frame_credit (rx_push_credit),
        .rx_overrun   (rx_overrun)
    );

    credit_fifo #(
        .payload_t    (rx_frame_t),
        .INIT_CREDITS (RX_HOST_CREDITS)
    ) i_rx_fifo (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .in_valid   (rx_push),
        .in_data    (rx_push_frame),
        .in_credit  (rx_push_credit),
        .out_valid  (rx_valid),
        .out_data   (rx_frame),
        .out_credit (rx_credit)
    );

endmodule

// File: source/uart_rx_ctrl.sv
// uart receive FSM
// two-flop synchronizer, start bit check at half bit, samples at bit centres
// stop bit check and credit-based push with overrun drop

`timescale 1ns/1ps

module uart_rx_ctrl import uart_pkg::*; (
    input  logic      sys_clk,
    input  logic      sys_rst,
    input  logic      rxd,
    output logic      run,
    output logic      half,
    input  logic      tick,
    output logic      frame_valid,
    output rx_frame_t frame_data,
    input  logic      frame_credit,
    output logic      rx_overrun
);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_t;

    state_t                         state;
    logic                           rxd_meta;
    logic                           rxd_sync;
    logic                           rxd_prev;  // for falling edge detect
    logic [DATA_BITS-1:0]           shreg;
    logic [$clog2(DATA_BITS)-1:0]   bit_cnt;
    logic [CNT_W-1:0]               credits;   // free slots in the rx buffer
    logic                           frame_done;
    logic                           push;

    assign half       = state == START;  // first tick lands mid start bit
    assign frame_done = (state == STOP) && tick;
    assign push       = frame_done && (credits != 0);

    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            state       <= IDLE;
            run         <= 1'b0;
            bit_cnt     <= '0;
            frame_valid <= 1'b0;
            rx_overrun  <= 1'b0;
            credits     <= CNT_W'(FIFO_DEPTH);
        end else begin
            frame_valid <= push;
            rx_overrun  <= frame_done && (credits == 0);  // frame dropped

            if (push && !frame_credit)
                credits <= credits - 1'b1;
            else if (frame_credit && !push)
                credits <= credits + 1'b1;

            case (state)
                IDLE: begin
                    if (rxd_prev && !rxd_sync) begin
                        state <= START;
                        run   <= 1'b1;
                    end
                end
                START: begin
                    if (tick) begin
                        if (!rxd_sync) begin
                            state   <= DATA;
                            bit_cnt <= '0;
                        end else begin
                            state <= IDLE;  // glitch, not a start bit
                            run   <= 1'b0;
                        end
                    end
                end
                DATA: begin
                    if (tick) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == DATA_BITS - 1)
                            state <= STOP;
                    end
                end
                STOP: begin
                    // back to idle at the stop centre so the next start edge is seen
                    if (tick) begin
                        state <= IDLE;
                        run   <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // data path, lsb arrives first
    always_ff @(posedge sys_clk) begin
        if ((state == DATA) && tick)
            shreg <= {rxd_sync, shreg[DATA_BITS-1:1]};
        if (frame_done) begin
            frame_data.data      <= shreg;
            frame_data.frame_err <= !rxd_sync;  // stop bit low
        end
    end

endmodule

// File: source/uart_tx_ctrl.sv
// uart transmit FSM
// start bit, DATA_BITS data bits lsb first, one stop bit
// credit back to the buffer when the stop bit ends

`timescale 1ns/1ps

module uart_tx_ctrl import uart_pkg::*; (
    input  logic       sys_clk,
    input  logic       sys_rst,
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    output logic       byte_credit,
    output logic       run,
    input  logic       tick,
    output logic       txd,
    output logic       tx_busy
);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } state_t;

    state_t                         state;
    logic [DATA_BITS-1:0]           shreg;
    logic [$clog2(DATA_BITS)-1:0]   bit_cnt;
    logic                           shift;

    assign tx_busy     = state != IDLE;
    assign byte_credit = (state == STOP) && tick;  // last cycle of the stop bit
    assign shift       = tick && ((state == START) || (state == DATA));

    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            state   <= IDLE;
            run     <= 1'b0;
            txd     <= 1'b1;  // line idles high
            bit_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (byte_valid) begin
                        state <= START;
                        run   <= 1'b1;
                        txd   <= 1'b0;  // start bit
                    end
                end
                START: begin
                    if (tick) begin
                        state   <= DATA;
                        txd     <= shreg[0];
                        bit_cnt <= '0;
                    end
                end
                DATA: begin
                    if (tick) begin
                        if (bit_cnt == DATA_BITS - 1) begin
                            state <= STOP;
                            txd   <= 1'b1;
                        end else begin
                            txd     <= shreg[0];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                STOP: begin
                    if (tick) begin
                        state <= IDLE;
                        run   <= 1'b0;  // clears the baud counter
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // shift register feeds txd from its low bit
    always_ff @(posedge sys_clk) begin
        if ((state == IDLE) && byte_valid)
            shreg <= byte_data;
        else if (shift)
            shreg <= shreg >> 1;
    end

    // only one frame in flight, the buffer waits for our credit
    assert property (@(posedge sys_clk) disable iff (!sys_rst)
        byte_valid |-> state == IDLE)
        else $error("byte offered while a frame is in flight");

endmodule

// File: source/credit_fifo.sv
// small circular buffer with credit-based flow control on both sides
// in_credit returns one credit upstream per pop
// downstream credit counter gates the pops

`timescale 1ns/1ps

module credit_fifo import uart_pkg::*; #(
    parameter type payload_t    = logic [7:0],
    parameter int  INIT_CREDITS = 1
) (
    input  logic     sys_clk,
    input  logic     sys_rst,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_credit,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_credit
);

    payload_t                        mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
    logic [CNT_W-1:0]                count;
    logic [CNT_W-1:0]                credits;  // downstream credits held
    logic                            pop;

    assign pop = (count != 0) && (credits != 0);

    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            credits   <= CNT_W'(INIT_CREDITS);
            out_valid <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            out_valid <= pop;
            in_credit <= pop;  // slot freed, hand it back upstream

            if (in_valid)
                wr_ptr <= (wr_ptr == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;

            if (in_valid && !pop)
                count <= count + 1'b1;
            else if (pop && !in_valid)
                count <= count - 1'b1;

            if (pop && !out_credit)
                credits <= credits - 1'b1;
            else if (out_credit && !pop)
                credits <= credits + 1'b1;
        end
    end

    // storage and output data
    always_ff @(posedge sys_clk) begin
        if (in_valid)
            mem[wr_ptr] <= in_data;
        if (pop)
            out_data <= mem[rd_ptr];
    end

    // upstream must respect the credits it was given
    assert property (@(posedge sys_clk) disable iff (!sys_rst)
        in_valid |-> count != FIFO_DEPTH)
        else $error("push into full buffer");

    // downstream never returns more than it was handed
    assert property (@(posedge sys_clk) disable iff (!sys_rst)
        out_credit |-> (credits < INIT_CREDITS) || pop)
        else $error("credit returned beyond initial count");

endmodule

// File: source/baud_timer.sv
// bit period counter
// ticks once per bit while run is high, optional half-length first period

`timescale 1ns/1ps

module baud_timer import uart_pkg::*; (
    input  logic sys_clk,
    input  logic sys_rst,
    input  logic run,
    input  logic half,
    output logic tick
);

    logic [$clog2(CLKS_PER_BIT)-1:0] cnt;
    logic                            first;  // still in the first period after run rose
    logic                            last;

    // half only matters for the first period
    assign last = (first && half) ? (cnt == HALF_BIT - 1) : (cnt == CLKS_PER_BIT - 1);
    assign tick = run && last;

    always_ff @(posedge sys_clk or negedge sys_rst) begin
        if (!sys_rst) begin
            cnt   <= '0;
            first <= 1'b1;
        end else if (!run) begin
            cnt   <= '0;
            first <= 1'b1;
        end else if (tick) begin
            cnt   <= '0;  // wrap at end of bit
            first <= 1'b0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // half shortens only the first period, so it has to come up together with run
    assert property (@(posedge sys_clk) disable iff (!sys_rst)
        $rose(half) |-> $rose(run))
        else $error("half raised after the bit period had started");

endmodule

// File: source/uart_pkg.sv
// shared constants for the uart subsystem
// bit timing, buffer sizing, credit counts, received frame type

package uart_pkg;

    // serial timing
    localparam int SYS_CLK_HZ   = 25_000_000;
    localparam int BAUD_RATE    = 1_562_500;
    localparam int CLKS_PER_BIT = SYS_CLK_HZ / BAUD_RATE;  // 16 clocks per bit
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;

    // frame layout
    localparam int DATA_BITS = 8;

    // buffering and flow control
    localparam int FIFO_DEPTH      = 4;
    localparam int RX_HOST_CREDITS = 2;
    localparam int CNT_W           = $clog2(FIFO_DEPTH + 1);  // occupancy and credit counters

    // one received frame as stored in the rx buffer
    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        logic                 frame_err;  // stop bit sampled low
    } rx_frame_t;

endpackage
